// ==== include/exec_macros.svh ====
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// data word width
`define EXEC_XLEN 32

// shift amount wide enough to address every bit of a word
`define EXEC_SHAMT_W 5

// funct3 in bits 2..0 and funct7 bit 5 on bit 8
`define EXEC_FUNC_W 10

`endif

// ==== rtl/exec_pkg.sv ====
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]    word_t;
    typedef logic [`EXEC_SHAMT_W-1:0] shamt_t;
    typedef logic [`EXEC_FUNC_W-1:0]  func_t;

    // position of the alternate bit in func
    localparam int FUNC_ALT_BIT = 8;

    // funct3 for register/immediate alu operations
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for branch compares
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        word_t data1;
        word_t data2;
        func_t func;
    } exec_req_t;

    typedef struct packed {
        word_t result;
        logic  compare;
    } exec_resp_t;

endpackage

`default_nettype wire

// ==== rtl/left_barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module left_barrel_shifter (
    input  exec_pkg::word_t  idata,
    input  exec_pkg::shamt_t shift_len,
    output exec_pkg::word_t  odata
);
    import exec_pkg::*;

    // level 0 is the input, level i+1 is level i shifted by 2**i or passed
    word_t level [0:`EXEC_SHAMT_W];

    assign level[0] = idata;

    for (genvar i = 0; i < `EXEC_SHAMT_W; i++) begin : g_level
        localparam int STEP = 1 << i;

        word_t shifted;

        // zeros come in from the right
        assign shifted = {level[i][`EXEC_XLEN-1-STEP:0], {STEP{1'b0}}};

        assign level[i+1] = shift_len[i] ? shifted : level[i];
    end

    assign odata = level[`EXEC_SHAMT_W];

endmodule

`default_nettype wire

// ==== rtl/right_barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module right_barrel_shifter (
    input  exec_pkg::word_t  idata,
    input  exec_pkg::shamt_t shift_len,
    input  logic             arithmetic,
    output exec_pkg::word_t  odata
);
    import exec_pkg::*;

    logic  fill;
    word_t level [0:`EXEC_SHAMT_W];

    // sign extension for sra, zeros for srl
    assign fill = arithmetic & idata[`EXEC_XLEN-1];

    assign level[0] = idata;

    for (genvar i = 0; i < `EXEC_SHAMT_W; i++) begin : g_level
        localparam int STEP = 1 << i;

        word_t shifted;

        assign shifted = {{STEP{fill}}, level[i][`EXEC_XLEN-1:STEP]};

        assign level[i+1] = shift_len[i] ? shifted : level[i];
    end

    assign odata = level[`EXEC_SHAMT_W];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module alu (
    input  exec_pkg::word_t data1,
    input  exec_pkg::word_t data2,
    input  exec_pkg::func_t func,
    output exec_pkg::word_t odata,
    output logic            compare_val
);
    import exec_pkg::*;

    logic [2:0]          funct3;
    logic                alt;
    shamt_t              shamt;

    word_t               sum;
    logic [`EXEC_XLEN:0] diff;
    logic                equal;
    logic                less_signed;
    logic                less_unsigned;

    word_t               and_bits;
    word_t               or_bits;
    word_t               xor_bits;
    word_t               shl_bits;
    word_t               shr_bits;

    assign funct3 = func[2:0];
    assign alt    = func[FUNC_ALT_BIT];

    // only the low bits of data2 count as shift amount
    assign shamt  = data2[`EXEC_SHAMT_W-1:0];

    left_barrel_shifter i_left_barrel_shifter (
        .idata     (data1),
        .shift_len (shamt),
        .odata     (shl_bits)
    );

    right_barrel_shifter i_right_barrel_shifter (
        .idata      (data1),
        .shift_len  (shamt),
        .arithmetic (alt),
        .odata      (shr_bits)
    );

    assign sum = data1 + data2;

    // one subtract feeds sub, slt/sltu and all branch compares
    // bit XLEN is the borrow out
    assign diff = {1'b0, data1} - {1'b0, data2};

    assign equal         = (diff[`EXEC_XLEN-1:0] == '0);
    assign less_unsigned = diff[`EXEC_XLEN];

    // signs differ means the negative one is smaller
    assign less_signed = (data1[`EXEC_XLEN-1] != data2[`EXEC_XLEN-1]) ?
                         data1[`EXEC_XLEN-1] : diff[`EXEC_XLEN-1];

    assign and_bits = data1 & data2;
    assign or_bits  = data1 | data2;
    assign xor_bits = data1 ^ data2;

    always_comb begin
        case (funct3)
            F3_ADD_SUB: odata = alt ? diff[`EXEC_XLEN-1:0] : sum;
            F3_SLL:     odata = shl_bits;
            F3_SLT:     odata = {{(`EXEC_XLEN-1){1'b0}}, less_signed};
            F3_SLTU:    odata = {{(`EXEC_XLEN-1){1'b0}}, less_unsigned};
            F3_XOR:     odata = xor_bits;
            F3_SRL_SRA: odata = shr_bits;
            F3_OR:      odata = or_bits;
            F3_AND:     odata = and_bits;
            default:    odata = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  compare_val = equal;
            F3_BNE:  compare_val = ~equal;
            F3_BLT:  compare_val = less_signed;
            F3_BGE:  compare_val = ~less_signed;
            F3_BLTU: compare_val = less_unsigned;
            F3_BGEU: compare_val = ~less_unsigned;
            // 010 and 011 are not branch codes
            default: compare_val = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                 clk,
    input  logic                 reset,

    input  exec_pkg::exec_req_t  req,
    input  logic                 req_valid,
    output logic                 req_ready,

    output exec_pkg::exec_resp_t resp,
    output logic                 resp_valid,
    input  logic                 resp_ready
);
    import exec_pkg::*;

    // stage 1 holds the request, stage 2 is the resp register itself
    exec_req_t  s1_req;
    logic       s1_valid;

    logic       s1_advance;
    logic       s2_advance;
    logic       req_fire;
    logic       s1_move;

    exec_resp_t alu_resp;

    // stage 2 can take a new item when empty or draining this cycle
    assign s2_advance = ~resp_valid | resp_ready;

    // stage 1 can take a new item when empty or passing its item on
    assign s1_advance = ~s1_valid | s2_advance;

    assign req_ready = s1_advance;
    assign req_fire  = req_valid & s1_advance;
    assign s1_move   = s1_valid & s2_advance;

    alu i_alu (
        .data1       (s1_req.data1),
        .data2       (s1_req.data2),
        .func        (s1_req.func),
        .odata       (alu_resp.result),
        .compare_val (alu_resp.compare)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (s1_advance) begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            s1_req <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (s2_advance) begin
            resp_valid <= s1_valid;
        end
    end

    // held while the consumer stalls
    always_ff @(posedge clk) begin
        if (s1_move) begin
            resp <= alu_resp;
        end
    end

endmodule

`default_nettype wire

// ==== verif/exec_unit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 req_valid,
    input logic                 req_ready,
    input exec_pkg::exec_resp_t resp,
    input logic                 resp_valid,
    input logic                 resp_ready
);

    // stalled response keeps valid and payload
    property resp_held_p;
        @(posedge clk) disable iff (reset)
            resp_valid && !resp_ready |=> resp_valid && $stable(resp);
    endproperty

    property resp_valid_known_p;
        @(posedge clk) disable iff (reset)
            !$isunknown(resp_valid);
    endproperty

    // a draining cycle with no new request leaves stage 1 empty
    property ready_follows_p;
        @(posedge clk) disable iff (reset)
            resp_ready && !(req_valid && req_ready) |=> req_ready;
    endproperty

    resp_held_a: assert property (resp_held_p)
        else $error("resp changed or was dropped while stalled");

    resp_valid_known_a: assert property (resp_valid_known_p)
        else $error("resp_valid is unknown");

    ready_follows_a: assert property (ready_follows_p)
        else $error("req_ready low after a drain cycle with no request");

endmodule

bind exec_unit exec_unit_assert i_exec_unit_assert (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
);

`default_nettype wire

// ==== verif/exec_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;
    import exec_pkg::*;

    localparam int NUM_TXN     = 2000;
    localparam int STEADY_TXN  = 200;
    localparam int RUN_LIMIT   = 20000;
    localparam int DRAIN_LIMIT = 50;

    typedef struct packed {
        exec_resp_t  resp;
        logic [31:0] cycle;
        logic        timed;
    } expect_t;

    logic        clk;
    logic        reset;
    exec_req_t   req;
    logic        req_valid;
    logic        req_ready;
    exec_resp_t  resp;
    logic        resp_valid;
    logic        resp_ready;

    // sampled at the falling edge, used at the following rising edge
    exec_req_t   req_s;
    exec_resp_t  resp_s;
    logic        req_valid_s;
    logic        req_fire_s;
    logic        resp_fire_s;

    expect_t     pending [$];
    int unsigned accepted;
    int unsigned cycles;
    int unsigned drain_start;
    logic        steady;

    exec_unit i_exec_unit (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, expected);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "stopped on failure");
    endtask

    function automatic word_t random_word();
        case ($urandom_range(0, 9))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h0000_0001;
            default: return $urandom();
        endcase
    endfunction

    function automatic exec_req_t random_request();
        exec_req_t  r;
        logic [2:0] f3;
        logic       alt;
        r.data1 = random_word();
        // equal operands now and then for the beq and bge edges
        if ($urandom_range(0, 7) == 0) begin
            r.data2 = r.data1;
        end else begin
            r.data2 = random_word();
        end
        f3     = 3'($urandom_range(0, 7));
        alt    = 1'($urandom_range(0, 1));
        r.func = {1'b0, alt, 5'b0, f3};
        return r;
    endfunction

    function automatic exec_resp_t expected_response(input exec_req_t r);
        exec_resp_t         e;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [4:0]         sh;
        logic [2:0]         f3;
        logic               alt;
        sa  = r.data1;
        sb  = r.data2;
        sh  = r.data2[4:0];
        f3  = r.func[2:0];
        alt = r.func[8];
        case (f3)
            F3_ADD_SUB: e.result = alt ? r.data1 - r.data2 : r.data1 + r.data2;
            F3_SLL:     e.result = r.data1 << sh;
            F3_SLT:     e.result = 32'(sa < sb);
            F3_SLTU:    e.result = 32'(r.data1 < r.data2);
            F3_XOR:     e.result = r.data1 ^ r.data2;
            F3_SRL_SRA: begin
                if (alt) begin
                    e.result = sa >>> sh;
                end else begin
                    e.result = r.data1 >> sh;
                end
            end
            F3_OR:      e.result = r.data1 | r.data2;
            default:    e.result = r.data1 & r.data2;
        endcase
        // branch reading of the same funct3
        case (f3)
            F3_BEQ:  e.compare = (r.data1 == r.data2);
            F3_BNE:  e.compare = (r.data1 != r.data2);
            F3_BLT:  e.compare = (sa < sb);
            F3_BGE:  e.compare = (sa >= sb);
            F3_BLTU: e.compare = (r.data1 < r.data2);
            F3_BGEU: e.compare = (r.data1 >= r.data2);
            default: e.compare = 1'b0;
        endcase
        return e;
    endfunction

    task automatic cycle_step();
        expect_t head;
        @(negedge clk);
        req_s       = req;
        resp_s      = resp;
        req_valid_s = req_valid;
        req_fire_s  = req_valid & req_ready;
        resp_fire_s = resp_valid & resp_ready;
        @(posedge clk);
        if (resp_fire_s) begin
            if (pending.size() == 0) begin
                report_failure("response transferred with no request outstanding");
            end else begin
                head = pending.pop_front();
                compare_value("resp.result", resp_s.result, head.resp.result);
                compare_value("resp.compare", 32'(resp_s.compare), 32'(head.resp.compare));
                if (head.timed) begin
                    compare_value("latency", cycles - head.cycle, 32'd2);
                end
            end
        end
        if (req_fire_s) begin
            head.resp  = expected_response(req_s);
            head.cycle = cycles;
            head.timed = steady;
            pending.push_back(head);
            accepted++;
        end
        cycles++;
        // last stretch runs without back-pressure to pin the latency
        steady = (accepted >= NUM_TXN - STEADY_TXN);
        if (req_fire_s || !req_valid_s) begin
            if (accepted < NUM_TXN) begin
                req       <= random_request();
                req_valid <= steady | ($urandom_range(0, 9) < 7);
            end else begin
                req_valid <= 1'b0;
            end
        end
        resp_ready <= steady | ($urandom_range(0, 9) < 6);
    endtask

    initial begin
        void'($urandom(48591));
        reset      <= 1'b1;
        req        <= '0;
        req_valid  <= 1'b0;
        resp_ready <= 1'b0;
        accepted   = 0;
        cycles     = 0;
        steady     = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_value("resp_valid", 32'(resp_valid), 32'd0);
        compare_value("req_ready", 32'(req_ready), 32'd1);
        while (accepted < NUM_TXN && cycles < RUN_LIMIT) begin
            cycle_step();
        end
        drain_start = cycles;
        while (pending.size() != 0 && cycles < drain_start + DRAIN_LIMIT) begin
            cycle_step();
        end
        // a stray extra response would show up here
        repeat (5) cycle_step();
        if (accepted < NUM_TXN) begin
            report_failure("timeout, not all requests were accepted");
        end else if (pending.size() != 0) begin
            report_failure("timeout, responses still outstanding after drain");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/exec_pkg.sv
rtl/left_barrel_shifter.sv
rtl/right_barrel_shifter.sv
rtl/alu.sv
rtl/exec_unit.sv
verif/exec_unit_assert.sv
verif/exec_unit_tb.sv

// ==== Makefile ====
TOP = exec_unit_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
